// File: common/mam_params.svh
`ifndef MAM_PARAMS_SVH
`define MAM_PARAMS_SVH

// Memory word width, multiple of 16
`define MAM_DATA_WIDTH 32

// Byte address width, one flit per 16 bits
`define MAM_ADDR_WIDTH 32

`define MAM_MAX_PKT_LEN 8 // Data flits per response packet

`define MAM_MEM_WORDS 256

`endif

// File: common/mam_pkg.sv
`include "mam_params.svh"

package mam_pkg;

   typedef logic [15:0] flit_t;
   typedef logic [`MAM_DATA_WIDTH-1:0] word_t;
   typedef logic [`MAM_ADDR_WIDTH-1:0] addr_t;
   typedef logic [13:0] beats_t;
   typedef logic [`MAM_DATA_WIDTH/8-1:0] strb_t;
   typedef logic [9:0] node_id_t;

   typedef enum logic [3:0] {
      ING_IDLE, ING_SKIP, ING_CMD, ING_ADDR, ING_REQ,
      ING_WR_HDR, ING_WRITE, ING_WR_WAIT,
      ING_SWRITE, ING_SWR_WAIT, ING_RD_BUSY
   } ingress_state_t;

   typedef enum logic [1:0] {
      EG_IDLE,
      EG_HDR,
      EG_DATA
   } egress_state_t;

endpackage

// File: common/mam_mem_if.sv
`timescale 1ns/1ns

interface mam_mem_if import mam_pkg::*; ();

   logic   req_valid;
   logic   req_ready;
   logic   req_rw;     // 1 is write
   addr_t  req_addr;
   logic   req_burst;
   beats_t req_beats;

   logic   write_valid;
   word_t  write_data;
   strb_t  write_strb; // Single writes only
   logic   write_ready;

   logic   read_valid;
   word_t  read_data;
   logic   read_ready;

   modport req_side (
      output req_valid, req_rw, req_addr, req_burst, req_beats,
      output write_valid, write_data, write_strb,
      input  req_ready, write_ready
   );

   modport rd_side (output read_ready, input read_valid, read_data);

   modport mem (
      output req_ready, write_ready, read_valid, read_data,
      input  req_valid, req_rw, req_addr, req_burst, req_beats,
      input  write_valid, write_data, write_strb, read_ready
   );

endinterface

// File: mam/mam_ingress.sv
`timescale 1ns/1ns

`include "mam_params.svh"

module mam_ingress import mam_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  flit_t       in_data,
   input  logic        in_valid,
   input  logic        in_last,
   output logic        in_ready,
   mam_mem_if.req_side mem,
   output logic        rd_start,
   output beats_t      rd_beats,
   input  logic        rd_done
);

   localparam int FLITS      = `MAM_DATA_WIDTH / 16;
   localparam int ADDR_FLITS = `MAM_ADDR_WIDTH / 16;

   ingress_state_t state, nxt_state;
   logic [$clog2(ADDR_FLITS + 2)-1:0] cnt, nxt_cnt; // Address and header flits
   logic [$clog2(FLITS + 1)-1:0] wcnt, nxt_wcnt;    // Flits of the current word
   logic   cmd_rw;
   logic   cmd_burst;
   logic   last_addr; // Packet ended with the address
   logic   in_packet;
   beats_t beats;
   addr_t  addr;
   strb_t  strb;
   word_t  word_q;
   logic   flit_in;
   logic   word_done;

   assign in_ready = !rst && state inside {ING_IDLE, ING_SKIP, ING_CMD, ING_ADDR,
                                           ING_WR_HDR, ING_WRITE, ING_SWRITE};
   assign flit_in   = in_valid && in_ready;
   assign word_done = flit_in && (wcnt == FLITS - 1);

   assign mem.req_rw     = cmd_rw;
   assign mem.req_addr   = addr;
   assign mem.req_burst  = cmd_burst;
   assign mem.req_beats  = beats;
   assign mem.write_strb = strb;

   assign rd_start = (state == ING_REQ) && mem.req_ready && !cmd_rw;
   assign rd_beats = beats;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ING_IDLE;
         cnt   <= '0;
         wcnt  <= '0;
      end else begin
         state <= nxt_state;
         cnt   <= nxt_cnt;
         wcnt  <= nxt_wcnt;
      end

      if (flit_in && state == ING_CMD) begin
         cmd_rw    <= in_data[15];
         cmd_burst <= in_data[14];
         beats     <= in_data[14] ? in_data[13:0] : beats_t'(1);
         strb      <= in_data[$bits(strb_t)-1:0];
      end else if (mem.write_valid && mem.write_ready) begin
         beats <= beats - 1'b1;
      end

      if (flit_in && state == ING_ADDR) begin
         addr      <= {addr[`MAM_ADDR_WIDTH-17:0], in_data}; // High half first
         last_addr <= in_last;
      end

      if (flit_in && (state == ING_WRITE || state == ING_SWRITE))
         word_q <= mem.write_data;
      if (word_done && state == ING_WRITE)
         in_packet <= !in_last;
   end

   always_comb begin
      nxt_state       = state;
      nxt_cnt         = cnt;
      nxt_wcnt        = wcnt;
      mem.req_valid   = 1'b0;
      mem.write_valid = 1'b0;
      mem.write_data  = word_q;

      case (state)
         ING_IDLE: if (in_valid) nxt_state = ING_SKIP;
         ING_SKIP: if (in_valid) nxt_state = ING_CMD;
         ING_CMD: begin
            if (in_valid) begin
               nxt_state = ING_ADDR;
               nxt_cnt   = '0;
            end
         end
         ING_ADDR: begin
            if (in_valid) begin
               nxt_cnt = cnt + 1'b1;
               if (cnt == ADDR_FLITS - 1) nxt_state = ING_REQ;
            end
         end
         ING_REQ: begin
            mem.req_valid = 1'b1;
            if (mem.req_ready) begin
               nxt_cnt  = '0;
               nxt_wcnt = '0;
               if (!cmd_rw)
                  nxt_state = ING_RD_BUSY;
               else if (!cmd_burst)
                  nxt_state = ING_SWRITE;
               else
                  nxt_state = last_addr ? ING_WR_HDR : ING_WRITE;
            end
         end
         ING_WR_HDR: begin // Headers of a continuation packet
            if (in_valid) begin
               nxt_cnt = cnt + 1'b1;
               if (cnt == 1) nxt_state = ING_WRITE;
            end
         end
         ING_WRITE, ING_SWRITE: begin
            mem.write_data[(FLITS - wcnt) * 16 - 1 -: 16] = in_data;
            if (in_valid) nxt_wcnt = wcnt + 1'b1;
            if (word_done) begin
               nxt_wcnt        = '0;
               mem.write_valid = 1'b1;
            end
            if (state == ING_SWRITE) begin
               if (word_done)
                  nxt_state = mem.write_ready ? ING_IDLE : ING_SWR_WAIT;
            end else if (word_done && !mem.write_ready) begin
               nxt_state = ING_WR_WAIT;
            end else if (word_done && beats == 1) begin
               nxt_state = ING_IDLE;
            end else if (in_valid && in_last) begin
               nxt_state = ING_WR_HDR;
               nxt_cnt   = '0;
            end
         end
         ING_WR_WAIT: begin
            mem.write_valid = 1'b1;
            if (mem.write_ready) begin
               nxt_cnt = '0;
               if (beats == 1)
                  nxt_state = ING_IDLE;
               else
                  nxt_state = in_packet ? ING_WRITE : ING_WR_HDR;
            end
         end
         ING_SWR_WAIT: begin
            mem.write_valid = 1'b1;
            if (mem.write_ready) nxt_state = ING_IDLE;
         end
         ING_RD_BUSY: if (rd_done) nxt_state = ING_IDLE;
         default: nxt_state = ING_IDLE;
      endcase
   end

endmodule

// File: mam/mam_egress.sv
`timescale 1ns/1ns

`include "mam_params.svh"

module mam_egress import mam_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  node_id_t   id,
   mam_mem_if.rd_side mem,
   input  logic       rd_start,
   input  beats_t     rd_beats,
   output logic       rd_done,
   output flit_t      out_data,
   output logic       out_valid,
   output logic       out_last,
   input  logic       out_ready
);

   localparam int FLITS   = `MAM_DATA_WIDTH / 16;
   localparam int PKT_LEN = `MAM_MAX_PKT_LEN;

   egress_state_t state, nxt_state;
   logic   hcnt, nxt_hcnt; // Second header flit
   logic [$clog2(PKT_LEN)-1:0] pcnt, nxt_pcnt;
   logic [$clog2(FLITS + 1)-1:0] wcnt, nxt_wcnt;
   beats_t left, nxt_left; // Words still to send
   logic   pkt_end;
   logic   word_end;
   logic   nxt_done;

   assign pkt_end  = (pcnt == PKT_LEN - 1);
   assign word_end = (wcnt == FLITS - 1);

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= EG_IDLE;
         hcnt    <= 1'b0;
         rd_done <= 1'b0;
      end else begin
         state   <= nxt_state;
         hcnt    <= nxt_hcnt;
         rd_done <= nxt_done;
      end
      pcnt <= nxt_pcnt;
      wcnt <= nxt_wcnt;
      left <= nxt_left;
   end

   always_comb begin
      nxt_state      = state;
      nxt_hcnt       = hcnt;
      nxt_pcnt       = pcnt;
      nxt_wcnt       = wcnt;
      nxt_left       = left;
      nxt_done       = 1'b0;
      out_valid      = 1'b0;
      out_last       = 1'b0;
      out_data       = '0;
      mem.read_ready = 1'b0;

      case (state)
         EG_IDLE: begin
            if (rd_start) begin
               nxt_state = EG_HDR;
               nxt_left  = rd_beats;
               nxt_wcnt  = '0;
            end
         end
         EG_HDR: begin
            out_valid = 1'b1;
            out_data  = hcnt ? {2'b01, 4'b1111, id} : 16'h0000;
            if (out_ready) begin
               nxt_hcnt = !hcnt;
               if (hcnt) begin
                  nxt_state = EG_DATA;
                  nxt_pcnt  = '0;
               end
            end
         end
         EG_DATA: begin
            out_valid = mem.read_valid;
            out_data  = mem.read_data[`MAM_DATA_WIDTH - 1 - 16 * wcnt -: 16];
            out_last  = pkt_end || (word_end && left == 1);
            if (mem.read_valid && out_ready) begin
               nxt_pcnt = pcnt + 1'b1;
               nxt_wcnt = wcnt + 1'b1;
               if (word_end) begin
                  mem.read_ready = 1'b1;
                  nxt_wcnt       = '0;
                  nxt_left       = left - 1'b1;
               end
               if (word_end && left == 1) begin
                  nxt_state = EG_IDLE;
                  nxt_done  = 1'b1;
               end else if (pkt_end) begin
                  nxt_state = EG_HDR; // Fresh headers
               end
            end
         end
         default: nxt_state = EG_IDLE;
      endcase
   end

endmodule

// File: rtl/mam_sram.sv
`timescale 1ns/1ns

`include "mam_params.svh"

module mam_sram import mam_pkg::*; (
   input  logic   clk,
   input  logic   rst,
   mam_mem_if.mem mem
);

   localparam int IDX_W  = $clog2(`MAM_MEM_WORDS);
   localparam int OFS_W  = $clog2(`MAM_DATA_WIDTH / 8);
   localparam int STRB_W = `MAM_DATA_WIDTH / 8;

   word_t mem_q [`MAM_MEM_WORDS];
   logic [IDX_W-1:0] idx;
   logic [IDX_W-1:0] req_idx;
   beats_t cnt;      // Read beats left
   logic   burst_q;
   logic   rd_valid;
   word_t  rdata;
   logic   req_fire;
   logic   wr_fire;
   logic   rd_fire;

   assign req_idx  = mem.req_addr[OFS_W +: IDX_W]; // Wraps at depth
   assign req_fire = mem.req_valid && mem.req_ready;
   assign wr_fire  = mem.write_valid && mem.write_ready;
   assign rd_fire  = rd_valid && mem.read_ready;

   assign mem.req_ready   = 1'b1;
   assign mem.write_ready = 1'b1;
   assign mem.read_valid  = rd_valid;
   assign mem.read_data   = rdata;

   always_ff @(posedge clk) begin
      if (rst)
         rd_valid <= 1'b0;
      else if (req_fire && !mem.req_rw)
         rd_valid <= 1'b1;
      else if (rd_fire && cnt == 1)
         rd_valid <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (req_fire) begin
         burst_q <= mem.req_burst;
         cnt     <= mem.req_beats;
         if (mem.req_rw) begin
            idx <= req_idx;
         end else begin
            rdata <= mem_q[req_idx];
            idx   <= req_idx + 1'b1;
         end
      end else if (wr_fire) begin
         for (int b = 0; b < STRB_W; b++)
            if (burst_q || mem.write_strb[b])
               mem_q[idx][b*8 +: 8] <= mem.write_data[b*8 +: 8];
         idx <= idx + 1'b1;
      end else if (rd_fire && cnt != 1) begin
         rdata <= mem_q[idx];
         idx   <= idx + 1'b1;
         cnt   <= cnt - 1'b1;
      end
   end

endmodule

// File: rtl/mam_top.sv
`timescale 1ns/1ns

module mam_top import mam_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  node_id_t id,
   input  flit_t    debug_in_data,
   input  logic     debug_in_valid,
   input  logic     debug_in_last,
   output logic     debug_in_ready,
   output flit_t    debug_out_data,
   output logic     debug_out_valid,
   output logic     debug_out_last,
   input  logic     debug_out_ready
);

   logic   rd_start;
   logic   rd_done;
   beats_t rd_beats;

   mam_mem_if mem_if ();

   mam_ingress u_ingress (
      .clk      (clk),
      .rst      (rst),
      .in_data  (debug_in_data),
      .in_valid (debug_in_valid),
      .in_last  (debug_in_last),
      .in_ready (debug_in_ready),
      .mem      (mem_if.req_side),
      .rd_start (rd_start),
      .rd_beats (rd_beats),
      .rd_done  (rd_done)
   );

   mam_sram u_sram (
      .clk (clk),
      .rst (rst),
      .mem (mem_if.mem)
   );

   mam_egress u_egress (
      .clk       (clk),
      .rst       (rst),
      .id        (id),
      .mem       (mem_if.rd_side),
      .rd_start  (rd_start),
      .rd_beats  (rd_beats),
      .rd_done   (rd_done),
      .out_data  (debug_out_data),
      .out_valid (debug_out_valid),
      .out_last  (debug_out_last),
      .out_ready (debug_out_ready)
   );

endmodule

// File: test/mam_chk.sv
`timescale 1ns/1ns

module mam_chk import mam_pkg::*; (
   input logic  clk,
   input logic  rst,
   input logic  debug_in_valid,
   input logic  debug_in_ready,
   input flit_t debug_out_data,
   input logic  debug_out_valid,
   input logic  debug_out_last,
   input logic  debug_out_ready
);

   int fail_count = 0;

   out_valid_reset: assert property (@(posedge clk) rst |=> !debug_out_valid)
      else begin
         fail_count++;
         $error("debug_out_valid high after a reset cycle");
      end

   out_hold: assert property (@(posedge clk) disable iff (rst)
      debug_out_valid && !debug_out_ready |=>
         debug_out_valid && $stable(debug_out_data) && $stable(debug_out_last))
      else begin
         fail_count++;
         $error("Stalled response flit changed");
      end

   last_hold: assert property (@(posedge clk) disable iff (rst)
      $fell(debug_out_last) |-> $past(debug_out_valid && debug_out_ready))
      else begin
         fail_count++;
         $error("debug_out_last dropped without a transfer");
      end

   // No transfer on either side during reset
   no_xfer_reset: assert property (@(posedge clk)
      rst |-> !(debug_in_valid && debug_in_ready) && !(debug_out_valid && debug_out_ready))
      else begin
         fail_count++;
         $error("Flit transferred while in reset");
      end

endmodule

bind mam_top mam_chk u_chk (
   .clk             (clk),
   .rst             (rst),
   .debug_in_valid  (debug_in_valid),
   .debug_in_ready  (debug_in_ready),
   .debug_out_data  (debug_out_data),
   .debug_out_valid (debug_out_valid),
   .debug_out_last  (debug_out_last),
   .debug_out_ready (debug_out_ready)
);

// File: test/mam_tb.sv
`timescale 1ns/1ns

`include "mam_params.svh"

module mam_tb import mam_pkg::*; ();

   localparam int CLK_PERIOD  = 100;
   localparam int NUM_RANDOM  = 200;
   localparam int NUM_TXNS    = NUM_RANDOM + 64; // Fill and directed tests on top
   localparam int WORST_FLITS = 130;             // 20 beats split into one-flit packets
   localparam int FLIT_CYCLES = 8;               // Input gaps and output stalls
   localparam int WORDS       = `MAM_MEM_WORDS;
   localparam int PKT_LEN     = `MAM_MAX_PKT_LEN;
   localparam int FLITS       = `MAM_DATA_WIDTH / 16;
   localparam int ADDR_FLITS  = `MAM_ADDR_WIDTH / 16;

   logic     clk;
   logic     rst;
   node_id_t id;
   flit_t    debug_in_data;
   logic     debug_in_valid;
   logic     debug_in_last;
   logic     debug_in_ready;
   flit_t    debug_out_data;
   logic     debug_out_valid;
   logic     debug_out_last;
   logic     debug_out_ready;

   logic [7:0] model_mem [WORDS*4]; // Byte image of the SRAM
   flit_t exp_data [$];
   logic  exp_last [$];
   string cur_test;
   bit    gaps_en;
   bit    stall_en;
   int    data_errors = 0;
   int    last_errors = 0;
   int    other_errors = 0;

   mam_top DUT (
      .clk             (clk),
      .rst             (rst),
      .id              (id),
      .debug_in_data   (debug_in_data),
      .debug_in_valid  (debug_in_valid),
      .debug_in_last   (debug_in_last),
      .debug_in_ready  (debug_in_ready),
      .debug_out_data  (debug_out_data),
      .debug_out_valid (debug_out_valid),
      .debug_out_last  (debug_out_last),
      .debug_out_ready (debug_out_ready)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic int rand_range(input int lo, input int hi);
      return lo + int'($urandom % (hi - lo + 1));
   endfunction

   function automatic int word_index(input addr_t addr, input int i);
      return int'(((addr >> 2) + i) % WORDS); // Wraps at depth
   endfunction

   function automatic void model_write(input int idx, input word_t w, input strb_t strb);
      for (int b = 0; b < $bits(strb_t); b++)
         if (strb[b])
            model_mem[idx*4 + b] = w[b*8 +: 8];
   endfunction

   function automatic word_t model_read(input int idx);
      word_t w;
      for (int b = 0; b < $bits(strb_t); b++)
         w[b*8 +: 8] = model_mem[idx*4 + b];
      return w;
   endfunction

   task automatic send_flit(input flit_t data, input logic last);
      bit accepted;
      int gap;
      gap = (gaps_en && $urandom % 4 == 0) ? rand_range(1, 3) : 0;
      repeat (gap) begin
         @(posedge clk);
         #10;
      end
      debug_in_valid = 1'b1;
      debug_in_data  = data;
      debug_in_last  = last;
      do begin
         @(negedge clk);
         accepted = debug_in_ready; // Stable until the next edge
         @(posedge clk);
         #10;
      end while (!accepted);
      debug_in_valid = 1'b0;
   endtask

   task automatic send_header();
      send_flit(flit_t'($urandom), 1'b0); // Destination
      send_flit(flit_t'($urandom), 1'b0); // Source
   endtask

   task automatic send_cmd_addr(input flit_t cmd, input addr_t addr, input logic last);
      send_header();
      send_flit(cmd, 1'b0);
      for (int f = 0; f < ADDR_FLITS; f++)
         send_flit(addr[`MAM_ADDR_WIDTH-1-16*f -: 16], last && f == ADDR_FLITS - 1);
   endtask

   task automatic single_write(input addr_t addr, input word_t w, input strb_t strb);
      model_write(word_index(addr, 0), w, strb);
      send_cmd_addr(16'h8000 | flit_t'(strb), addr, 1'b0);
      for (int f = 0; f < FLITS; f++)
         send_flit(w[`MAM_DATA_WIDTH-1-16*f -: 16], f == FLITS - 1);
   endtask

   task automatic burst_write(input addr_t addr, input int beats, input bit split);
      flit_t flits [$];
      word_t w;
      int    chunk;
      int    pos;
      for (int i = 0; i < beats; i++) begin
         w = word_t'({$urandom, $urandom});
         model_write(word_index(addr, i), w, '1);
         for (int f = 0; f < FLITS; f++)
            flits.push_back(w[`MAM_DATA_WIDTH-1-16*f -: 16]);
      end
      chunk = split ? rand_range(0, flits.size() - 1) : flits.size();
      send_cmd_addr(16'hC000 | flit_t'(beats), addr, chunk == 0);
      for (int i = 0; i < chunk; i++)
         send_flit(flits[i], i == chunk - 1);
      pos = chunk;
      while (pos < flits.size()) begin
         chunk = rand_range(1, 6);
         if (chunk > flits.size() - pos)
            chunk = flits.size() - pos;
         send_header(); // Continuation packet
         for (int i = 0; i < chunk; i++)
            send_flit(flits[pos + i], i == chunk - 1);
         pos += chunk;
      end
   endtask

   task automatic send_read(input addr_t addr, input int beats, input bit burst);
      word_t w;
      int    n;
      n = 0;
      for (int i = 0; i < beats; i++) begin
         w = model_read(word_index(addr, i));
         for (int f = 0; f < FLITS; f++) begin
            if (n % PKT_LEN == 0) begin
               exp_data.push_back(16'h0000);
               exp_data.push_back({2'b01, 4'b1111, id});
               exp_last.push_back(1'b0);
               exp_last.push_back(1'b0);
            end
            exp_data.push_back(w[`MAM_DATA_WIDTH-1-16*f -: 16]);
            exp_last.push_back(n % PKT_LEN == PKT_LEN - 1 || (i == beats - 1 && f == FLITS - 1));
            n++;
         end
      end
      send_cmd_addr(burst ? 16'h4000 | flit_t'(beats) : 16'h0000, addr, 1'b1);
   endtask

   task automatic wait_responses();
      while (exp_data.size() != 0) begin
         @(posedge clk);
         #10;
      end
   endtask

   initial begin : collector
      flit_t e_data;
      logic  e_last;
      forever begin
         @(negedge clk);
         if (!rst && debug_out_valid && debug_out_ready) begin
            if (exp_data.size() == 0) begin
               $display("Unexpected response flit %h in test %s", debug_out_data, cur_test);
               other_errors++;
            end else begin
               e_data = exp_data.pop_front();
               e_last = exp_last.pop_front();
               if (debug_out_data !== e_data) begin
                  $display("FAIL %s: flit expected %h actual %h", cur_test, e_data,
                           debug_out_data);
                  data_errors++;
               end
               if (debug_out_last !== e_last) begin
                  $display("FAIL %s: last expected %b actual %b", cur_test, e_last,
                           debug_out_last);
                  last_errors++;
               end
            end
         end
      end
   end

   initial begin : sink_ready
      debug_out_ready = 1'b1;
      forever begin
         @(posedge clk);
         #10;
         debug_out_ready = stall_en ? ($urandom % 4 != 0) : 1'b1;
      end
   end

   initial begin : watchdog
      #(longint'(NUM_TXNS) * WORST_FLITS * FLIT_CYCLES * CLK_PERIOD);
      $display("Watchdog timeout, the run did not complete in time");
      $display("Checks failed");
      $finish;
   end

   initial begin : main
      addr_t a;
      int    beats;
      int    assert_errors;
      void'($urandom(22999));
      rst            = 1'b1;
      id             = node_id_t'($urandom);
      debug_in_data  = '0;
      debug_in_valid = 1'b1; // Offered through reset, never taken
      debug_in_last  = 1'b0;
      gaps_en        = 1'b0;
      stall_en       = 1'b0;
      cur_test       = "reset";
      repeat (8) @(posedge clk);
      #10;
      rst            = 1'b0;
      debug_in_valid = 1'b0;
      @(negedge clk);

      if (debug_out_valid !== 1'b0) begin
         $display("FAIL %s: debug_out_valid expected 0 actual %b", cur_test, debug_out_valid);
         other_errors++;
      end
      if (debug_in_ready !== 1'b1) begin
         $display("FAIL %s: debug_in_ready expected 1 actual %b", cur_test, debug_in_ready);
         other_errors++;
      end
      @(posedge clk);
      #10;

      cur_test = "fill";
      for (int i = 0; i < WORDS; i += 16)
         burst_write(addr_t'(i * 4), 16, 1'b0);

      cur_test = "strobe";
      repeat (8) begin
         a = $urandom;
         single_write(a, $urandom, strb_t'($urandom));
         send_read(a, 1, 1'b0);
      end
      wait_responses();

      cur_test = "burst";
      repeat (4) begin
         a = $urandom;
         burst_write(a, 20, 1'b1);
         send_read(a, 20, 1'b1);
      end
      wait_responses();

      cur_test = "alias";
      repeat (4) begin
         a = addr_t'(rand_range(0, WORDS - 1) * 4);
         single_write(a, $urandom, '1);
         send_read(a + addr_t'(rand_range(1, 1023)) * (WORDS * 4), 1, 1'b0);
      end
      wait_responses();

      cur_test = "random";
      gaps_en  = 1'b1;
      stall_en = 1'b1;
      repeat (NUM_RANDOM) begin
         a     = $urandom;
         beats = rand_range(1, 20);
         case ($urandom % 4)
            0:       single_write(a, $urandom, strb_t'($urandom));
            1:       burst_write(a, beats, $urandom % 2);
            2:       send_read(a, 1, 1'b0);
            default: send_read(a, beats, 1'b1);
         endcase
      end
      wait_responses();

      repeat (4) @(posedge clk);
      assert_errors = DUT.u_chk.fail_count;
      $display("Errors: data %0d, last %0d, other %0d, assertions %0d",
               data_errors, last_errors, other_errors, assert_errors);
      if (data_errors + last_errors + other_errors + assert_errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

// File: filelist.f
+incdir+common
common/mam_pkg.sv
common/mam_mem_if.sv
mam/mam_ingress.sv
mam/mam_egress.sv
rtl/mam_sram.sv
rtl/mam_top.sv
test/mam_chk.sv
test/mam_tb.sv

// File: Bender.yml
package:
  name: mam

sources:
  - include_dirs:
      - common
    files:
      - common/mam_pkg.sv
      - common/mam_mem_if.sv
      - mam/mam_ingress.sv
      - mam/mam_egress.sv
      - rtl/mam_sram.sv
      - rtl/mam_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/mam_chk.sv
      - test/mam_tb.sv
